// ==== src/tart_cfg_pkg.sv ====
package tart_cfg_pkg;

   // ------------------------------------------------------------
   // Instrument widths
   // ------------------------------------------------------------

   // Slave bus data, one byte per transfer
   localparam int BUS_WIDTH = 8;

   // Raw antenna word, three bytes from DRAM
   localparam int SAMPLE_WIDTH = 24;

   // Visibilities-per-block count seen by the correlator
   localparam int ACCUM_WIDTH = 24;

   // Block counter, 32 stored visibility blocks
   localparam int BLOCK_BITS = 5;

   // Acquisition write address into DRAM
   localparam int AQ_ADR_WIDTH = 25;

endpackage

// ==== src/tart_reg_pkg.sv ====
package tart_reg_pkg;

   // ------------------------------------------------------------
   // Register map, 4-bit address
   // ------------------------------------------------------------

   // Raw antenna data
   localparam logic [3:0] AX_STREAM = 4'h0;
   localparam logic [3:0] AX_DATA1 = 4'h1;
   localparam logic [3:0] AX_DATA2 = 4'h2;
   localparam logic [3:0] AX_DATA3 = 4'h3;

   // Acquisition status and control
   localparam logic [3:0] AQ_STATUS = 4'h4;
   localparam logic [3:0] AQ_DEBUG = 4'h6;
   localparam logic [3:0] AQ_SYSTEM = 4'h7;

   // Visibilities access, status and control
   localparam logic [3:0] VX_STREAM = 4'h8;
   localparam logic [3:0] VX_STATUS = 4'h9;
   localparam logic [3:0] VX_SYSTEM = 4'ha;

   // Field positions inside the control registers
   localparam int ENABLE_BIT = 7;
   localparam int OVERWRITE_BIT = 6;
   localparam int LOG_BLOCK_WIDTH = 5;
   localparam int DELAY_WIDTH = 3;

endpackage

// ==== src/dram_prefetch.sv ====
`timescale 1ns/1ns

module dram_prefetch (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   // DRAM side
   input  logic                                  data_ready_i,
   input  logic [tart_cfg_pkg::SAMPLE_WIDTH-1:0] data_in_i,
   output logic                                  data_request_o,
   // Reader side
   input  logic                                  word_taken_i,
   output logic                                  word_valid_o,
   output logic [tart_cfg_pkg::SAMPLE_WIDTH-1:0] word_data_o
);

   // Two-word ring plus one request in flight
   logic [tart_cfg_pkg::SAMPLE_WIDTH-1:0] ring [2];
   logic       wr_ptr;
   logic       rd_ptr;
   logic [1:0] count;
   logic       pending;
   logic       pop;

   assign word_valid_o = (count != 2'd0);
   assign word_data_o  = ring[rd_ptr];
   assign pop          = word_taken_i && word_valid_o;

   // Store each returning word at the tail
   always_ff @(posedge clk_i) begin
      if (data_ready_i) begin
         ring[wr_ptr] <= data_in_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (data_ready_i) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         // Push and pop together keep the fill level
         case ({data_ready_i, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Request generation
   // ------------------------------------------------------------

   // Held words plus the one in flight never exceed two
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         data_request_o <= 1'b0;
         pending        <= 1'b0;
      end else begin
         data_request_o <= 1'b0;
         if (data_ready_i) begin
            pending <= 1'b0;
         end
         if (!pending && count < 2'd2) begin
            data_request_o <= 1'b1;
            pending        <= 1'b1;
         end
      end
   end

endmodule

// ==== src/acq_regs.sv ====
`timescale 1ns/1ns

module acq_regs (
   // Slave bus
   input  logic                                     clk_i,
   input  logic                                     rst_i,
   input  logic                                     cyc_i,
   input  logic                                     stb_i,
   input  logic                                     we_i,
   input  logic [3:0]                               adr_i,
   input  logic [tart_cfg_pkg::BUS_WIDTH-1:0]       dat_i,
   output logic                                     ack_o,
   output logic [tart_cfg_pkg::BUS_WIDTH-1:0]       dat_o,
   // Visibilities master bus
   output logic                                     vx_cyc_o,
   output logic                                     vx_stb_o,
   input  logic                                     vx_ack_i,
   input  logic [tart_cfg_pkg::BUS_WIDTH-1:0]       vx_dat_i,
   // Block flags and unit status
   input  logic                                     overflow_i,
   input  logic                                     newblock_i,
   input  logic                                     streamed_i,
   input  logic                                     vx_stuck_i,
   input  logic                                     vx_limp_i,
   input  logic [tart_cfg_pkg::AQ_ADR_WIDTH-1:0]    aq_adr_i,
   input  logic                                     spi_busy_i,
   // Control outputs
   output logic [tart_cfg_pkg::BLOCK_BITS-1:0]      vx_blk_o,
   output logic [tart_cfg_pkg::ACCUM_WIDTH-1:0]     blocksize_o,
   output logic                                     vx_enabled_o,
   output logic                                     vx_overwrite_o,
   output logic                                     aq_enabled_o,
   output logic                                     aq_debug_mode_o,
   output logic [tart_reg_pkg::DELAY_WIDTH-1:0]     aq_sample_delay_o,
   output logic                                     available_o,
   output logic                                     accessed_o,
   // Prefetch buffer
   input  logic                                     word_valid_i,
   input  logic [tart_cfg_pkg::SAMPLE_WIDTH-1:0]    word_data_i,
   output logic                                     word_taken_o
);

   logic request;
   logic wr_req;
   logic x_ack;
   logic send;
   logic [1:0] byte_idx;
   logic [tart_cfg_pkg::BUS_WIDTH-1:0] ax_stream;
   logic [tart_cfg_pkg::BUS_WIDTH-1:0] aq_debug;
   logic [tart_cfg_pkg::BUS_WIDTH-1:0] aq_system;
   logic [tart_cfg_pkg::BUS_WIDTH-1:0] vx_status;
   logic [tart_cfg_pkg::BUS_WIDTH-1:0] vx_system;
   logic [tart_reg_pkg::LOG_BLOCK_WIDTH-1:0] log_block;
   logic [tart_cfg_pkg::BLOCK_BITS-1:0] new_blk;
   logic upd_blk;
   logic bs_upd;
   logic [tart_cfg_pkg::ACCUM_WIDTH-1:0] bs_pow;

   // New request of a classic cycle only
   assign request = cyc_i && stb_i && !ack_o;
   assign wr_req  = request && we_i;

   // Pass-through strobe to the visibilities unit
   assign vx_cyc_o = cyc_i;
   assign vx_stb_o = request && (adr_i == tart_reg_pkg::VX_STREAM);

   // Acknowledged visibilities read and sent antenna byte
   assign x_ack = vx_stb_o && !we_i && vx_ack_i;
   assign send  = request && !we_i && (adr_i == tart_reg_pkg::AX_STREAM) && word_valid_i;

   // ------------------------------------------------------------
   // Read formats
   // ------------------------------------------------------------
   always_comb begin
      aq_debug = '0;
      aq_debug[tart_reg_pkg::ENABLE_BIT]     = aq_debug_mode_o;
      aq_debug[tart_reg_pkg::ENABLE_BIT - 1] = vx_stuck_i;
      aq_debug[tart_reg_pkg::ENABLE_BIT - 2] = vx_limp_i;

      aq_system = '0;
      aq_system[tart_reg_pkg::ENABLE_BIT] = aq_enabled_o;
      aq_system[tart_reg_pkg::DELAY_WIDTH-1:0] = aq_sample_delay_o;

      vx_system = '0;
      vx_system[tart_reg_pkg::ENABLE_BIT]    = vx_enabled_o;
      vx_system[tart_reg_pkg::OVERWRITE_BIT] = vx_overwrite_o;
      vx_system[tart_reg_pkg::LOG_BLOCK_WIDTH-1:0] = log_block;
   end

   // Flags in the top three bits and counter below
   assign vx_status = {available_o, accessed_o, overflow_i, vx_blk_o};

   // Head word bytes from high to low
   always_comb begin
      case (byte_idx)
         2'd0:    ax_stream = word_data_i[23:16];
         2'd1:    ax_stream = word_data_i[15:8];
         default: ax_stream = word_data_i[7:0];
      endcase
   end

   // ------------------------------------------------------------
   // Bus acknowledge and read data
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else if (request) begin
         if (adr_i == tart_reg_pkg::VX_STREAM) begin
            ack_o <= vx_ack_i;
         end else if (adr_i == tart_reg_pkg::AX_STREAM && !we_i) begin
            // Stall until DRAM has filled the head
            ack_o <= word_valid_i;
         end else begin
            ack_o <= 1'b1;
         end
      end else begin
         ack_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (request && !we_i) begin
         case (adr_i)
            tart_reg_pkg::AX_STREAM: dat_o <= ax_stream;
            tart_reg_pkg::AX_DATA1:  dat_o <= word_valid_i ? word_data_i[23:16] : '0;
            tart_reg_pkg::AX_DATA2:  dat_o <= word_valid_i ? word_data_i[15:8] : '0;
            tart_reg_pkg::AX_DATA3:  dat_o <= word_valid_i ? word_data_i[7:0] : '0;
            tart_reg_pkg::AQ_STATUS: dat_o <= aq_adr_i[tart_cfg_pkg::BUS_WIDTH-1:0];
            tart_reg_pkg::AQ_DEBUG:  dat_o <= aq_debug;
            tart_reg_pkg::AQ_SYSTEM: dat_o <= aq_system;
            tart_reg_pkg::VX_STREAM: dat_o <= vx_dat_i;
            tart_reg_pkg::VX_STATUS: dat_o <= vx_status;
            tart_reg_pkg::VX_SYSTEM: dat_o <= vx_system;
            default:                 dat_o <= '0;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         aq_enabled_o      <= 1'b0;
         aq_debug_mode_o   <= 1'b0;
         aq_sample_delay_o <= '0;
         vx_overwrite_o    <= 1'b0;
         log_block         <= '0;
         upd_blk           <= 1'b0;
      end else begin
         upd_blk <= 1'b0;
         if (wr_req) begin
            case (adr_i)
               tart_reg_pkg::AQ_DEBUG: begin
                  aq_debug_mode_o <= dat_i[tart_reg_pkg::ENABLE_BIT];
               end
               tart_reg_pkg::AQ_SYSTEM: begin
                  aq_enabled_o      <= dat_i[tart_reg_pkg::ENABLE_BIT];
                  aq_sample_delay_o <= dat_i[tart_reg_pkg::DELAY_WIDTH-1:0];
               end
               // Counter loads on the following edge
               tart_reg_pkg::VX_STATUS: begin
                  upd_blk <= 1'b1;
               end
               tart_reg_pkg::VX_SYSTEM: begin
                  vx_overwrite_o <= dat_i[tart_reg_pkg::OVERWRITE_BIT];
                  log_block      <= dat_i[tart_reg_pkg::LOG_BLOCK_WIDTH-1:0];
               end
               default: begin
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_req && adr_i == tart_reg_pkg::VX_STATUS) begin
         new_blk <= dat_i[tart_cfg_pkg::BLOCK_BITS-1:0];
      end
   end

   // Write wins over overflow auto-disable
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vx_enabled_o <= 1'b0;
      end else if (wr_req && adr_i == tart_reg_pkg::VX_SYSTEM) begin
         vx_enabled_o <= dat_i[tart_reg_pkg::ENABLE_BIT];
      end else if (overflow_i && !vx_overwrite_o) begin
         vx_enabled_o <= 1'b0;
      end
   end

   // ------------------------------------------------------------
   // Block bookkeeping
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         available_o <= 1'b0;
         accessed_o  <= 1'b0;
      end else if (newblock_i) begin
         available_o <= 1'b1;
         accessed_o  <= 1'b0;
      end else if (x_ack) begin
         available_o <= 1'b0;
         accessed_o  <= 1'b1;
      end
   end

   // Wraps after the last block
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vx_blk_o <= '0;
      end else if (upd_blk) begin
         vx_blk_o <= new_blk;
      end else if (streamed_i) begin
         vx_blk_o <= vx_blk_o + 1'b1;
      end
   end

   // Blocksize is 2^log_block minus 1 and saturates from 24 up
   assign bs_pow = (tart_cfg_pkg::ACCUM_WIDTH)'(1) << log_block;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bs_upd      <= 1'b0;
         blocksize_o <= '0;
      end else begin
         bs_upd <= wr_req && (adr_i == tart_reg_pkg::VX_SYSTEM);
         if (bs_upd) begin
            if (log_block >= tart_cfg_pkg::ACCUM_WIDTH) begin
               blocksize_o <= '1;
            end else begin
               blocksize_o <= bs_pow - 1'b1;
            end
         end
      end
   end

   // ------------------------------------------------------------
   // Antenna byte sequencing
   // ------------------------------------------------------------

   // Index restarts whenever SPI goes idle
   always_ff @(posedge clk_i) begin
      if (rst_i || !spi_busy_i) begin
         byte_idx <= 2'd0;
      end else if (send) begin
         byte_idx <= (byte_idx == 2'd2) ? 2'd0 : byte_idx + 2'd1;
      end
   end

   // Pop the head along with the low-byte ack
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         word_taken_o <= 1'b0;
      end else begin
         word_taken_o <= send && (byte_idx == 2'd2);
      end
   end

endmodule

// ==== src/tart_acq_top.sv ====
`timescale 1ns/1ns

module tart_acq_top (
   // Slave bus
   input  logic                                     clk_i,
   input  logic                                     rst_i,
   input  logic                                     cyc_i,
   input  logic                                     stb_i,
   input  logic                                     we_i,
   input  logic [3:0]                               adr_i,
   input  logic [tart_cfg_pkg::BUS_WIDTH-1:0]       dat_i,
   output logic                                     ack_o,
   output logic [tart_cfg_pkg::BUS_WIDTH-1:0]       dat_o,
   // Visibilities unit
   output logic                                     vx_cyc_o,
   output logic                                     vx_stb_o,
   input  logic                                     vx_ack_i,
   input  logic [tart_cfg_pkg::BUS_WIDTH-1:0]       vx_dat_i,
   input  logic                                     overflow_i,
   input  logic                                     newblock_i,
   input  logic                                     streamed_i,
   input  logic                                     vx_stuck_i,
   input  logic                                     vx_limp_i,
   // Acquisition unit and SPI
   input  logic [tart_cfg_pkg::AQ_ADR_WIDTH-1:0]    aq_adr_i,
   input  logic                                     spi_busy_i,
   // Settings
   output logic [tart_cfg_pkg::BLOCK_BITS-1:0]      vx_blk_o,
   output logic [tart_cfg_pkg::ACCUM_WIDTH-1:0]     blocksize_o,
   output logic                                     vx_enabled_o,
   output logic                                     vx_overwrite_o,
   output logic                                     aq_enabled_o,
   output logic                                     aq_debug_mode_o,
   output logic [tart_reg_pkg::DELAY_WIDTH-1:0]     aq_sample_delay_o,
   output logic                                     available_o,
   output logic                                     accessed_o,
   // DRAM
   input  logic                                     data_ready_i,
   input  logic [tart_cfg_pkg::SAMPLE_WIDTH-1:0]    data_in_i,
   output logic                                     data_request_o
);

   // Head of the prefetch buffer
   logic                                  word_valid;
   logic [tart_cfg_pkg::SAMPLE_WIDTH-1:0] word_data;
   logic                                  word_taken;

   acq_regs u_acq_regs (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .cyc_i             (cyc_i),
      .stb_i             (stb_i),
      .we_i              (we_i),
      .adr_i             (adr_i),
      .dat_i             (dat_i),
      .ack_o             (ack_o),
      .dat_o             (dat_o),
      .vx_cyc_o          (vx_cyc_o),
      .vx_stb_o          (vx_stb_o),
      .vx_ack_i          (vx_ack_i),
      .vx_dat_i          (vx_dat_i),
      .overflow_i        (overflow_i),
      .newblock_i        (newblock_i),
      .streamed_i        (streamed_i),
      .vx_stuck_i        (vx_stuck_i),
      .vx_limp_i         (vx_limp_i),
      .aq_adr_i          (aq_adr_i),
      .spi_busy_i        (spi_busy_i),
      .vx_blk_o          (vx_blk_o),
      .blocksize_o       (blocksize_o),
      .vx_enabled_o      (vx_enabled_o),
      .vx_overwrite_o    (vx_overwrite_o),
      .aq_enabled_o      (aq_enabled_o),
      .aq_debug_mode_o   (aq_debug_mode_o),
      .aq_sample_delay_o (aq_sample_delay_o),
      .available_o       (available_o),
      .accessed_o        (accessed_o),
      .word_valid_i      (word_valid),
      .word_data_i       (word_data),
      .word_taken_o      (word_taken)
   );

   // Keeps DRAM one or two words ahead of the reader
   dram_prefetch u_dram_prefetch (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .data_ready_i   (data_ready_i),
      .data_in_i      (data_in_i),
      .data_request_o (data_request_o),
      .word_taken_i   (word_taken),
      .word_valid_o   (word_valid),
      .word_data_o    (word_data)
   );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
   output logic clk_o
);

   // Free-running clock, 4 ns period
   initial begin
      clk_o = 1'b0;
      forever begin
         // Half period
         #2 clk_o = ~clk_o;
      end
   end

endmodule

// ==== verification/tart_acq_chk.sv ====
`timescale 1ns/1ns

module tart_acq_chk (
   input logic       clk_i,
   input logic       rst_i,
   input logic       ack_i,
   input logic       data_request_i,
   input logic       data_ready_i,
   input logic       vx_stb_i,
   input logic [3:0] adr_i
);

   // DRAM word requested and not yet returned
   logic outstanding;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         outstanding <= 1'b0;
      end else if (data_request_i) begin
         outstanding <= 1'b1;
      end else if (data_ready_i) begin
         outstanding <= 1'b0;
      end
   end

   // ------------------------------------------------------------
   // Bus and prefetch protocol
   // ------------------------------------------------------------

   // Classic cycle, one ack per strobe
   ack_single: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
      else $error("ack_o held high on two consecutive cycles");

   // One DRAM request in flight at most
   request_single: assert property (@(posedge clk_i) disable iff (rst_i)
      data_request_i |-> !outstanding)
      else $error("data_request_o issued while a DRAM request is outstanding");

   // Pass-through strobe only for the stream address
   vx_strobe_addr: assert property (@(posedge clk_i) disable iff (rst_i)
      vx_stb_i |-> (adr_i == tart_reg_pkg::VX_STREAM))
      else $error("vx_stb_o high for an address other than VX_STREAM");

endmodule

bind tart_acq_top tart_acq_chk u_acq_chk (
   .clk_i          (clk_i),
   .rst_i          (rst_i),
   .ack_i          (ack_o),
   .data_request_i (data_request_o),
   .data_ready_i   (data_ready_i),
   .vx_stb_i       (vx_stb_o),
   .adr_i          (adr_i)
);

// ==== verification/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;

   // Four table entries per stimulus line
   localparam int MAX_OPS = 128;
   localparam logic [23:0] OP_END = 24'hf;

   logic                                  clk;
   logic                                  rst_i;
   // Slave bus
   logic                                  cyc_i;
   logic                                  stb_i;
   logic                                  we_i;
   logic [3:0]                            adr_i;
   logic [tart_cfg_pkg::BUS_WIDTH-1:0]    dat_i;
   logic                                  ack_o;
   logic [tart_cfg_pkg::BUS_WIDTH-1:0]    dat_o;
   // Visibilities unit
   logic                                  vx_cyc_o;
   logic                                  vx_stb_o;
   logic                                  vx_ack_i;
   logic [tart_cfg_pkg::BUS_WIDTH-1:0]    vx_dat_i;
   logic                                  overflow_i;
   logic                                  newblock_i;
   logic                                  streamed_i;
   logic                                  vx_stuck_i;
   logic                                  vx_limp_i;
   logic [tart_cfg_pkg::AQ_ADR_WIDTH-1:0] aq_adr_i;
   logic                                  spi_busy_i;
   // Control outputs
   logic [tart_cfg_pkg::BLOCK_BITS-1:0]   vx_blk_o;
   logic [tart_cfg_pkg::ACCUM_WIDTH-1:0]  blocksize_o;
   logic                                  vx_enabled_o;
   logic                                  vx_overwrite_o;
   logic                                  aq_enabled_o;
   logic                                  aq_debug_mode_o;
   logic [tart_reg_pkg::DELAY_WIDTH-1:0]  aq_sample_delay_o;
   logic                                  available_o;
   logic                                  accessed_o;
   // DRAM
   logic                                  data_ready_i;
   logic [tart_cfg_pkg::SAMPLE_WIDTH-1:0] data_in_i;
   logic                                  data_request_o;

   // Op address data and expected value per line
   logic [23:0] stim [0:4*MAX_OPS-1];
   int cycle_count = 0;
   int cycle_limit = 0;

   tb_clock u_clock (
      .clk_o (clk)
   );

   tart_acq_top DUT (
      .clk_i (clk),
      .*
   );

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------

   // 8-bit Fibonacci LFSR with taps 8 6 5 4
   function automatic logic [7:0] lfsr_step(input logic [7:0] state);
      return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
   endfunction

   // Output selector codes used by the stimulus file
   function automatic logic [23:0] read_output(input logic [3:0] sel);
      logic [23:0] value;
      case (sel)
         4'd0:    value = {23'd0, aq_enabled_o};
         4'd1:    value = {21'd0, aq_sample_delay_o};
         4'd2:    value = {23'd0, vx_enabled_o};
         4'd3:    value = {23'd0, vx_overwrite_o};
         4'd4:    value = blocksize_o;
         4'd5:    value = {19'd0, vx_blk_o};
         default: value = 24'hbadbad;
      endcase
      return value;
   endfunction

   task automatic check_value(input string what, input logic [23:0] actual,
                              input logic [23:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] t=%0t ns: %s gave %h, expected %h", $time, what, actual, expected);
         $display("Simulation finished: FAIL");
         $fatal(1, "Value mismatch");
      end
   endtask

   // One classic cycle held until ack_o
   task automatic bus_cycle(input logic write, input logic [3:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
      @(posedge clk);
      #1;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = write;
      adr_i = addr;
      dat_i = wdata;
      do begin
         @(posedge clk);
         #1;
      end while (!ack_o);
      rdata = dat_o;
      // Visibilities cycle accompanies a stream read
      if (addr == tart_reg_pkg::VX_STREAM) begin
         check_value("vx_cyc_o during VX_STREAM read", {23'd0, vx_cyc_o}, 24'd1);
      end
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic run_op(input int idx);
      logic [23:0] op;
      logic [3:0]  addr;
      logic [7:0]  data;
      logic [23:0] expected;
      logic [7:0]  rdata;
      op       = stim[4*idx];
      addr     = stim[4*idx+1][3:0];
      data     = stim[4*idx+2][7:0];
      expected = stim[4*idx+3];
      case (op)
         24'h0: bus_cycle(1'b1, addr, data, rdata);
         24'h1: begin
            bus_cycle(1'b0, addr, 8'h00, rdata);
            check_value($sformatf("line %0d read of address %h", idx, addr),
                        {16'd0, rdata}, expected);
            // Flag outputs follow the status and debug bits
            if (addr == tart_reg_pkg::VX_STATUS) begin
               check_value($sformatf("line %0d available_o", idx),
                           {23'd0, available_o}, {23'd0, expected[7]});
               check_value($sformatf("line %0d accessed_o", idx),
                           {23'd0, accessed_o}, {23'd0, expected[6]});
            end else if (addr == tart_reg_pkg::AQ_DEBUG) begin
               check_value($sformatf("line %0d aq_debug_mode_o", idx),
                           {23'd0, aq_debug_mode_o}, {23'd0, expected[7]});
            end
         end
         // Single-cycle flag pulses
         24'h2: begin
            @(posedge clk);
            #1;
            newblock_i = 1'b1;
            @(posedge clk);
            #1;
            newblock_i = 1'b0;
         end
         24'h3: begin
            @(posedge clk);
            #1;
            streamed_i = 1'b1;
            @(posedge clk);
            #1;
            streamed_i = 1'b0;
         end
         24'h4: begin
            @(posedge clk);
            #1;
            overflow_i = data[0];
         end
         24'h5: begin
            @(posedge clk);
            #1;
            check_value($sformatf("line %0d output %0d", idx, addr), read_output(addr), expected);
         end
         default: begin
            $display("Stimulus line %0d holds an unknown operation code %h", idx, op);
            $display("Simulation finished: FAIL");
            $fatal(1, "Bad stimulus");
         end
      endcase
   endtask

   // ------------------------------------------------------------
   // DRAM model with 1 to 4 cycles per word
   // ------------------------------------------------------------
   initial begin : dram_model
      logic [7:0]  lfsr_state;
      logic [1:0]  delay_bits;
      logic [23:0] dram_word;
      int delay;
      lfsr_state   = 8'd80;
      dram_word    = 24'h123456;
      data_ready_i = 1'b0;
      data_in_i    = '0;
      forever begin
         @(negedge clk);
         if (data_request_o) begin
            // Two LFSR steps for the two delay bits
            lfsr_state    = lfsr_step(lfsr_state);
            delay_bits[0] = lfsr_state[0];
            lfsr_state    = lfsr_step(lfsr_state);
            delay_bits[1] = lfsr_state[0];
            delay         = int'(delay_bits) + 1;
            repeat (delay) @(posedge clk);
            #1;
            data_ready_i = 1'b1;
            data_in_i    = dram_word;
            // Every byte of the next word differs
            dram_word    = dram_word + 24'h111111;
            @(posedge clk);
            #1;
            data_ready_i = 1'b0;
         end
      end
   end

   // Visibilities unit answers one cycle after the strobe
   initial begin : vis_model
      vx_ack_i = 1'b0;
      vx_dat_i = '0;
      forever begin
         @(negedge clk);
         if (vx_stb_o && !we_i) begin
            @(posedge clk);
            #1;
            vx_ack_i = 1'b1;
            vx_dat_i = {3'b000, vx_blk_o} + 8'h40;
            @(posedge clk);
            #1;
            vx_ack_i = 1'b0;
         end
      end
   end

   // Hang guard
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("Run stopped after %0d cycles, the DUT stopped responding", cycle_count);
         $display("Simulation finished: FAIL");
         $fatal(1, "Timeout");
      end
   end

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin : main_seq
      int n_ops;
      rst_i      = 1'b1;
      cyc_i      = 1'b0;
      stb_i      = 1'b0;
      we_i       = 1'b0;
      adr_i      = '0;
      dat_i      = '0;
      overflow_i = 1'b0;
      newblock_i = 1'b0;
      streamed_i = 1'b0;
      vx_stuck_i = 1'b1;
      vx_limp_i  = 1'b0;
      aq_adr_i   = 25'h01234a5;
      // Byte index only runs while SPI is busy
      spi_busy_i = 1'b1;
      $readmemh("verification/acq_stimulus.txt", stim);
      n_ops = 0;
      while (n_ops < MAX_OPS && stim[4*n_ops] !== OP_END) begin
         n_ops++;
      end
      if (n_ops == MAX_OPS) begin
         $display("Stimulus file has no end marker");
         $display("Simulation finished: FAIL");
         $fatal(1, "Bad stimulus");
      end
      cycle_limit = 40 * n_ops + 100;
      repeat (2) @(posedge clk);
      #1;
      rst_i = 1'b0;
      for (int i = 0; i < n_ops; i++) begin
         run_op(i);
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== verification/acq_stimulus.txt ====
// op addr data expected, hex; op 0 write, 1 read, 2 newblock, 3 streamed
// op 4 overflow level in data, 5 output check (addr selects output), f end
// Acquisition control
0 7 85 0
1 7 0 85
5 0 0 1
5 1 0 5
0 6 80 0
1 6 0 c0
1 4 0 a5
// Visibilities control and block size
0 a c5 0
1 a 0 c5
5 2 0 1
5 3 0 1
5 4 0 1f
0 a c0 0
5 4 0 0
0 a d7 0
5 4 0 7fffff
0 a df 0
5 4 0 ffffff
// Overflow with and without overwrite
4 0 1 0
5 2 0 1
1 9 0 20
4 0 0 0
0 a 85 0
5 3 0 0
4 0 1 0
5 2 0 0
4 0 0 0
1 a 0 05
// Block flags and counter
2 0 0 0
1 9 0 80
1 8 0 40
1 9 0 40
0 9 1e 0
5 5 0 1e
3 0 0 0
3 0 0 0
5 5 0 0
3 0 0 0
1 8 0 41
1 9 0 41
// Antenna stream, DRAM words 123456 234567 345678 456789
1 1 0 12
1 3 0 56
1 0 0 12
1 0 0 34
1 0 0 56
1 0 0 23
1 2 0 45
1 0 0 45
1 0 0 67
1 0 0 34
1 0 0 56
1 0 0 78
1 0 0 45
1 0 0 67
1 0 0 89
f 0 0 0

// ==== src.f ====
src/tart_cfg_pkg.sv
src/tart_reg_pkg.sv
src/dram_prefetch.sv
src/acq_regs.sv
src/tart_acq_top.sv
verification/tb_clock.sv
verification/tart_acq_chk.sv
verification/tb_top.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_top
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
